// File: test/packet_buffer_tests.txt
# name packets length meta(hex) err stall(0 none, 1 random out_rdy)
# each packet has the given length, meta grows by one per packet, err only on the first.
single_1        1   1   a1  0   0
single_5        1   5   b2  0   0
single_8        1   8   c3  0   0
burst_10        10  8   10  0   0
burst_short     6   3   20  0   0
trunc_11        1   11  5e  0   0
err_then_clean  2   6   7f  1   0
stall_mix       4   3   33  0   1
stall_trunc     3   12  44  0   1
stall_err       2   8   90  1   1

// File: project.f
logic/pkt_buf_pkg.sv
logic/fifo_core.sv
logic/packet_descriptor_fifo.sv
logic/slot_allocator.sv
logic/packet_writer.sv
logic/packet_reader.sv
logic/packet_buffer_mem.sv
logic/packet_buffer.sv
test/tb_clock.sv
test/packet_buffer_tb.sv

// File: Bender.yml
package:
  name: packet_buffer

sources:
  - logic/pkt_buf_pkg.sv
  - logic/fifo_core.sv
  - logic/packet_descriptor_fifo.sv
  - logic/slot_allocator.sv
  - logic/packet_writer.sv
  - logic/packet_reader.sv
  - logic/packet_buffer_mem.sv
  - logic/packet_buffer.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/packet_buffer_tb.sv

// File: test/packet_buffer_tb.sv
`timescale 1ns/1ps

module packet_buffer_tb import pkt_buf_pkg::*; ();
    logic      clk;
    logic      arst_n;
    logic      in_vld;
    in_beat_t  in_beat;
    logic      in_rdy;
    logic      out_rdy;
    logic      out_vld;
    out_beat_t out_beat;

    // test table, one entry per row.
    string     t_name  [$];
    int        t_cnt   [$];
    int        t_len   [$];
    int        t_meta  [$];
    int        t_err   [$];
    int        t_stall [$];

    out_beat_t   exp_q [$];   // expected egress words in order.
    out_beat_t   exp_beat;
    out_beat_t   prev_beat;
    logic        held = 1'b0;
    logic        stall;
    string       cur_name = "reset";
    int          errors = 0;
    int          test_errs = 0;
    int          words_out = 0;
    int          passed = 0;
    int          failed = 0;
    int          pkts_in = 0;    // packets fully sent.
    int          pkts_out = 0;   // packets fully received.
    int          limit_cycles = 0;
    int unsigned seed_val;

    tb_clock #(.period(8.0), .rst_cycles(3)) i_tb_clock (.clk, .arst_n);

    packet_buffer uut (
        .clk, .arst_n,
        .in_vld, .in_beat, .in_rdy,
        .out_rdy, .out_vld, .out_beat
    );

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error: test %s expected %h actual %h", name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    r;
        string line;
        string nm;
        int    cnt;
        int    len;
        int    meta;
        int    err;
        int    stl;
        fd = $fopen("test/packet_buffer_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test table test/packet_buffer_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0 && line.getc(0) != "#") begin
                    r = $sscanf(line, "%s %d %d %h %d %d", nm, cnt, len, meta, err, stl);
                    if (r == 6) begin
                        t_name.push_back(nm);
                        t_cnt.push_back(cnt);
                        t_len.push_back(len);
                        t_meta.push_back(meta);
                        t_err.push_back(err);
                        t_stall.push_back(stl);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // ingress
    // ------------------------------
    task automatic send_packet(input int len, input logic [meta_wid-1:0] meta,
                               input logic err);
        in_beat_t  b;
        out_beat_t x;
        int        kept;
        kept = (len > max_pkt_size) ? max_pkt_size : len;   // the rest is dropped.
        for (int i = 0; i < len; i++) begin
            b.data = data_wid'($urandom);
            b.last = (i == len - 1);
            b.meta = b.last ? meta : '0;   // meta and err only matter on the last word.
            b.err  = b.last ? err : 1'b0;
            if (i < kept) begin
                x.data = b.data;
                x.last = (i == kept - 1);
                x.meta = meta;
                x.err  = err || (len > max_pkt_size);
                exp_q.push_back(x);
            end
            in_vld  <= 1'b1;
            in_beat <= b;
            @(negedge clk);
            while (!in_rdy) @(negedge clk);
            @(posedge clk);
        end
        pkts_in++;   // the whole packet now holds a slot.
    endtask

    task automatic run_test(input int t);
        cur_name  = t_name[t];
        stall     = t_stall[t] != 0;
        test_errs = 0;
        words_out = 0;
        for (int k = 0; k < t_cnt[t]; k++) begin
            // only the first packet of a row carries err.
            send_packet(t_len[t], meta_wid'(t_meta[t] + k), k == 0 && t_err[t] != 0);
        end
        in_vld <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        if (test_errs == 0) begin
            passed++;
            $display("test %s: ok, %0d words out", cur_name, words_out);
        end else begin
            failed++;
            $display("test %s: %0d errors", cur_name, test_errs);
        end
    endtask

    // ------------------------------
    // egress
    // ------------------------------
    initial begin : egress_ready
        out_rdy = 1'b0;
        forever begin
            @(posedge clk);
            out_rdy <= stall ? ($urandom % 2 == 0) : 1'b1;
        end
    end

    // sampled mid-cycle, a transfer happens at the next rising edge.
    always @(negedge clk) begin
        if (arst_n) begin
            // with every slot taken by a queued packet the writer has none to fill.
            if (pkts_in - pkts_out >= num_slots && in_rdy) begin
                $display("test %s: in_rdy high while every slot held a queued packet",
                         cur_name);
                errors++;
                test_errs++;
            end
            if (held && !out_vld) begin
                $display("test %s: out_vld dropped while a word was stalled", cur_name);
                errors++;
                test_errs++;
            end else if (held) begin
                check(cur_name, 32'(prev_beat), 32'(out_beat));
            end
            if (out_vld && out_rdy) begin
                if (exp_q.size() == 0) begin
                    $display("test %s: an egress word appeared with no packet pending", cur_name);
                    errors++;
                    test_errs++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check(cur_name, 32'(exp_beat), 32'(out_beat));
                    words_out++;
                    if (exp_beat.last) pkts_out++;
                end
            end
            held      = out_vld && !out_rdy;
            prev_beat = out_beat;
        end
    end

    initial begin : main
        int total_words;
        int total_pkts;
        int waited;
        in_vld      = 1'b0;
        in_beat     = '0;
        stall       = 1'b0;
        total_words = 0;
        total_pkts  = 0;
        seed_val    = $urandom(32'h0388_b66f);
        load_tests();
        foreach (t_cnt[i]) begin
            total_pkts  += t_cnt[i];
            total_words += t_cnt[i] * t_len[i];
        end
        limit_cycles = total_words * 4 + total_pkts * 8 + 100;

        wait (arst_n === 1'b1);
        @(negedge clk);
        check(cur_name, 32'(1'b0), 32'(out_vld));
        check(cur_name, 32'(1'b0), 32'(in_rdy));   // the free list is still filling.
        waited = 0;
        while (!in_rdy && waited <= num_slots + 4) begin   // allocator fill, then a claim.
            waited++;
            @(negedge clk);
        end
        if (!in_rdy) begin
            $display("in_rdy did not rise after the slot allocator fill");
            errors++;
        end
        @(posedge clk);
        if (errors == 0) begin
            for (int t = 0; t < t_name.size(); t++) run_test(t);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 t_name.size(), passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule : packet_buffer_tb

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real period     = 8.0,
    parameter int  rst_cycles = 3
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    // release away from the rising edge.
    initial begin
        arst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule : tb_clock

// File: logic/packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer import pkt_buf_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_vld,
    input  in_beat_t  in_beat,
    output logic      in_rdy,
    input  logic      out_rdy,
    output logic      out_vld,
    output out_beat_t out_beat
);
    // ------------------------------
    // internal wires
    // ------------------------------
    logic                alloc_vld;
    logic                alloc_rdy;
    slot_t               alloc_slot;
    logic                free_vld;
    slot_t               free_slot;
    logic                wr_vld;
    logic                wr_rdy;
    pkt_desc_t           wr_desc;
    logic                rd_vld;
    logic                rd_rdy;
    pkt_desc_t           rd_desc;
    logic                mem_wr;
    logic [addr_wid-1:0] mem_wr_addr;
    logic [data_wid-1:0] mem_wr_data;
    logic                mem_rd;
    logic [addr_wid-1:0] mem_rd_addr;
    logic [data_wid-1:0] mem_rd_data;

    slot_allocator i_slot_allocator (
        .clk, .arst_n,
        .alloc_rdy, .alloc_vld, .alloc_slot,
        .free_vld, .free_slot
    );

    packet_writer i_packet_writer (
        .clk, .arst_n,
        .in_vld, .in_beat, .in_rdy,
        .alloc_vld, .alloc_slot, .alloc_rdy,
        .wr_rdy, .wr_vld, .wr_desc,
        .mem_wr, .mem_wr_addr, .mem_wr_data
    );

    packet_buffer_mem i_packet_buffer_mem (
        .clk,
        .mem_wr, .mem_wr_addr, .mem_wr_data,
        .mem_rd, .mem_rd_addr, .mem_rd_data
    );

    packet_descriptor_fifo i_packet_descriptor_fifo (
        .clk, .arst_n,
        .wr_vld, .wr_desc, .wr_rdy,
        .rd_rdy, .rd_vld, .rd_desc,
        .desc_count ( )
    );

    packet_reader i_packet_reader (
        .clk, .arst_n,
        .rd_vld, .rd_desc, .rd_rdy,
        .mem_rd, .mem_rd_addr, .mem_rd_data,
        .out_rdy, .out_vld, .out_beat,
        .free_vld, .free_slot
    );

endmodule : packet_buffer

// File: logic/packet_buffer_mem.sv
`timescale 1ns/1ps

module packet_buffer_mem import pkt_buf_pkg::*; (
    input  logic                clk,
    input  logic                mem_wr,
    input  logic [addr_wid-1:0] mem_wr_addr,
    input  logic [data_wid-1:0] mem_wr_data,
    input  logic                mem_rd,
    input  logic [addr_wid-1:0] mem_rd_addr,
    output logic [data_wid-1:0] mem_rd_data
);
    logic [data_wid-1:0] mem [buf_words];

    always_ff @(posedge clk) begin
        if (mem_wr) mem[mem_wr_addr] <= mem_wr_data;
        if (mem_rd) mem_rd_data <= mem[mem_rd_addr];   // valid next cycle.
    end

endmodule : packet_buffer_mem

// File: logic/packet_reader.sv
`timescale 1ns/1ps

module packet_reader import pkt_buf_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rd_vld,
    input  pkt_desc_t           rd_desc,
    output logic                rd_rdy,
    output logic                mem_rd,
    output logic [addr_wid-1:0] mem_rd_addr,
    input  logic [data_wid-1:0] mem_rd_data,
    input  logic                out_rdy,
    output logic                out_vld,
    output out_beat_t           out_beat,
    output logic                free_vld,
    output slot_t               free_slot
);
    typedef enum logic [1:0] {st_idle, st_wait, st_hold} state_t;

    state_t              state;
    pkt_desc_t           desc_q;
    logic [size_wid-1:0] idx;       // word being read.
    logic [size_wid-1:0] idx_nxt;
    logic                acc;

    assign rd_rdy  = state == st_idle;
    assign out_vld = state == st_hold;
    assign acc     = out_vld && out_rdy;
    assign idx_nxt = idx + 1'b1;

    // first read comes with the pop, the rest with each accepted word.
    assign mem_rd      = (rd_rdy && rd_vld) || (acc && !out_beat.last);
    assign mem_rd_addr = rd_rdy ? rd_desc.addr : desc_q.addr + addr_wid'(idx_nxt);

    // ------------------------------
    // fsm
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            idx      <= '0;
            free_vld <= 1'b0;
        end else begin
            free_vld <= 1'b0;
            case (state)
                st_idle: if (rd_vld) begin
                    idx   <= '0;
                    state <= st_wait;
                end
                st_wait: state <= st_hold;  // memory latency.
                st_hold: if (out_rdy) begin
                    if (out_beat.last) begin
                        free_vld <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        idx   <= idx_nxt;
                        state <= st_wait;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_rdy && rd_vld) desc_q <= rd_desc;
        if (state == st_wait) begin
            out_beat.data <= mem_rd_data;
            out_beat.last <= idx_nxt == desc_q.size;
            out_beat.meta <= desc_q.meta;
            out_beat.err  <= desc_q.err;
        end
        if (acc && out_beat.last) free_slot <= desc_q.addr[addr_wid-1 -: slot_wid];
    end

endmodule : packet_reader

// File: logic/packet_writer.sv
`timescale 1ns/1ps

module packet_writer import pkt_buf_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_vld,
    input  in_beat_t            in_beat,
    output logic                in_rdy,
    input  logic                alloc_vld,
    input  slot_t               alloc_slot,
    output logic                alloc_rdy,
    input  logic                wr_rdy,
    output logic                wr_vld,
    output pkt_desc_t           wr_desc,
    output logic                mem_wr,
    output logic [addr_wid-1:0] mem_wr_addr,
    output logic [data_wid-1:0] mem_wr_data
);
    typedef enum logic [1:0] {st_claim, st_recv, st_push} state_t;

    state_t              state;
    logic [size_wid-1:0] idx;      // words stored so far.
    logic                drop;
    slot_t               slot_q;
    logic [meta_wid-1:0] meta_q;
    logic                err_q;

    assign alloc_rdy = state == st_claim;
    assign in_rdy    = state == st_recv;
    assign wr_vld    = state == st_push;

    assign drop        = idx == size_wid'(max_pkt_size);  // slot is full.
    assign mem_wr      = in_rdy && in_vld && !drop;
    assign mem_wr_addr = {slot_q, idx[addr_wid-slot_wid-1:0]};
    assign mem_wr_data = in_beat.data;

    always_comb begin
        wr_desc.addr = {slot_q, {(addr_wid - slot_wid){1'b0}}};
        wr_desc.size = idx;
        wr_desc.meta = meta_q;
        wr_desc.err  = err_q;
    end

    // ------------------------------
    // fsm
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_claim;
            idx     <= '0;
        end else begin
            case (state)
                st_claim: if (alloc_vld) begin
                    idx     <= '0;
                    state   <= st_recv;
                end
                st_recv: if (in_vld) begin
                    if (!drop) idx <= idx + 1'b1;   // oversize words are lost.
                    if (in_beat.last) state <= st_push;
                end
                st_push: if (wr_rdy) state <= st_claim;
                default: state <= st_claim;
            endcase
        end
    end

    // once the slot is full, drop stays set up to the last word.
    always_ff @(posedge clk) begin
        if (alloc_vld && alloc_rdy) slot_q <= alloc_slot;
        if (in_vld && in_rdy && in_beat.last) begin
            meta_q <= in_beat.meta;
            err_q  <= in_beat.err | drop;
        end
    end

endmodule : packet_writer

// File: logic/slot_allocator.sv
`timescale 1ns/1ps

module slot_allocator import pkt_buf_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  alloc_rdy,
    output logic  alloc_vld,
    output slot_t alloc_slot,
    input  logic  free_vld,
    input  slot_t free_slot
);
    logic [slot_wid:0] fill_cnt;
    logic              filling;
    logic              list_push;
    logic              list_rdy;
    logic              list_vld;
    slot_t             list_din;

    // ------------------------------
    // fill after reset
    // ------------------------------
    assign filling = fill_cnt != num_slots;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_cnt <= '0;
        end else if (filling) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign list_push = filling || free_vld;
    assign list_din  = filling ? fill_cnt[slot_wid-1:0] : free_slot;
    assign alloc_vld = list_vld && !filling;  // nothing goes out until the list is whole.

    fifo_core #(
        .payload_t ( slot_t ),
        .depth     ( num_slots )
    ) i_free_list (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .push      ( list_push ),
        .push_data ( list_din ),
        .push_rdy  ( list_rdy ),
        .pop       ( alloc_vld && alloc_rdy ),
        .pop_vld   ( list_vld ),
        .pop_data  ( alloc_slot ),
        .count     ( )
    );

    // a released slot must have been handed out before.
    a_free_not_full : assert property (@(posedge clk) disable iff (!arst_n)
        free_vld |-> list_rdy && !filling);

endmodule : slot_allocator

// File: logic/packet_descriptor_fifo.sv
`timescale 1ns/1ps

module packet_descriptor_fifo import pkt_buf_pkg::*; (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              wr_vld,
    input  pkt_desc_t                         wr_desc,
    output logic                              wr_rdy,
    input  logic                              rd_rdy,
    output logic                              rd_vld,
    output pkt_desc_t                         rd_desc,
    output logic [$clog2(desc_depth+1)-1:0]   desc_count
);

    fifo_core #(
        .payload_t ( pkt_desc_t ),
        .depth     ( desc_depth )
    ) i_fifo_core (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .push      ( wr_vld && wr_rdy ),
        .push_data ( wr_desc ),
        .push_rdy  ( wr_rdy ),
        .pop       ( rd_rdy && rd_vld ),
        .pop_vld   ( rd_vld ),
        .pop_data  ( rd_desc ),
        .count     ( desc_count )  // queued packets.
    );

    // the writer must hand over sane descriptors.
    a_desc_size : assert property (@(posedge clk) disable iff (!arst_n)
        wr_vld && wr_rdy |-> wr_desc.size >= 1 && wr_desc.size <= max_pkt_size);
    a_desc_align : assert property (@(posedge clk) disable iff (!arst_n)
        wr_vld && wr_rdy |-> wr_desc.addr % max_pkt_size == 0);

endmodule : packet_descriptor_fifo

// File: logic/fifo_core.sv
`timescale 1ns/1ps

module fifo_core #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         push,
    input  payload_t                     push_data,
    output logic                         push_rdy,
    input  logic                         pop,
    output logic                         pop_vld,
    output payload_t                     pop_data,
    output logic [$clog2(depth+1)-1:0]   count
);
    localparam int ptr_wid = (depth > 1) ? $clog2(depth) : 1;

    payload_t           mem [depth];
    logic [ptr_wid-1:0] wr_ptr;
    logic [ptr_wid-1:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign push_rdy = count != depth;
    assign pop_vld  = count != 0;
    assign pop_data = mem[rd_ptr];   // head is always visible.

    assign do_push = push && push_rdy;
    assign do_pop  = pop && pop_vld;

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_wid'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_wid'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both at once.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // the caller must respect push_rdy and pop_vld.
    a_no_push_full : assert property (@(posedge clk) disable iff (!arst_n)
        push |-> push_rdy);
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> pop_vld);

endmodule : fifo_core

// File: logic/pkt_buf_pkg.sv
package pkt_buf_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int data_wid     = 16;
    localparam int meta_wid     = 8;
    localparam int max_pkt_size = 8;                        // words per slot.
    localparam int num_slots    = 4;
    localparam int buf_words    = num_slots * max_pkt_size;
    localparam int addr_wid     = $clog2(buf_words);
    localparam int size_wid     = $clog2(max_pkt_size + 1); // holds 0 to max_pkt_size.
    localparam int slot_wid     = $clog2(num_slots);
    localparam int desc_depth   = 4;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [slot_wid-1:0] slot_t;

    // meta and err only count on the last word.
    typedef struct packed {
        logic [data_wid-1:0] data;
        logic                last;
        logic [meta_wid-1:0] meta;
        logic                err;
    } in_beat_t;

    typedef struct packed {
        logic [data_wid-1:0] data;
        logic                last;
        logic [meta_wid-1:0] meta;
        logic                err;
    } out_beat_t;

    typedef struct packed {
        logic [addr_wid-1:0] addr;  // slot base address.
        logic [size_wid-1:0] size;  // stored words.
        logic [meta_wid-1:0] meta;
        logic                err;
    } pkt_desc_t;

endpackage : pkt_buf_pkg
